/* cm_mem_pkg.sv */
/*
 * configuration memory package
 * geometry of the 1K x 18 cell memory, channel regions
 * and the structs on the host write side
 */
`default_nettype none

package cm_mem_pkg;

    localparam int cm_chn_num      = 4;     // channel regions
    localparam int cm_word_w       = 18;    // stored word width
    localparam int cm_addr_w       = 10;    // 1K words
    localparam int cm_region_words = 256;   // words per channel
    localparam int cm_eop_bit      = 16;    // end of frame marker

    typedef logic [cm_word_w-1:0]  cm_word_t;
    typedef logic [cm_addr_w-1:0]  cm_addr_t;
    typedef logic [1:0]            cm_chn_t;
    typedef logic [cm_chn_num-1:0] cm_chn_vec_t;

    // host write port, plain levels and strobes
    typedef struct packed {
        logic     sel;     // high for a whole frame
        cm_chn_t  chn;     // target region, steady while sel
        logic     wr_en;   // one word per strobe
        cm_word_t data;
    } cm_wr_port_t;

    // write controller to memory
    typedef struct packed {
        logic     en;
        cm_addr_t addr;
        cm_word_t data;
    } cm_ram_wr_t;

    // region base, channel times region size
    function automatic cm_addr_t cm_base_addr(cm_chn_t chn);
        return cm_addr_t'(int'(chn) * cm_region_words);
    endfunction

endpackage

`default_nettype wire

/* cm_frame_pkg.sv */
/*
 * configuration frame package
 * header word positions, header field constants, the
 * slot table and the read side structs
 */
`default_nettype none

package cm_frame_pkg;

    import cm_mem_pkg::*;

    // read sequence, seven header words then the body
    typedef enum logic [2:0] {
        head_da    = 3'd0,  // destination address
        head_da_sa = 3'd1,  // dest slot and source flag
        head_sa    = 3'd2,  // source address
        head_rsvd  = 3'd3,
        head_type  = 3'd4,
        head_tick  = 3'd5,  // tick position
        head_len   = 3'd6,
        head_body  = 3'd7   // stored words
    } cm_head_e;

    typedef logic [3:0] cm_slot_t;

    localparam logic [1:0]  cm_sof_tag      = 2'b10;
    localparam logic [2:0]  cm_box_num      = 3'd0;     // fixed extension box
    localparam logic [15:0] cm_cfg_type     = 16'h0C01;
    localparam logic [15:0] cm_cfg_data_len = 16'd264;
    localparam logic [15:0] cm_tick_pos     = 16'h0000;
    localparam logic [15:0] cm_len_word     = cm_cfg_data_len - 16'd8;  // minus header

    // destination slot per channel
    localparam cm_slot_t cm_slot_table [cm_chn_num] = '{4'd3, 4'd4, 4'd5, 4'd6};

    typedef struct packed {
        logic [7:0] dst_sta_num;
        logic       master;      // master/slave flag, bit 0 only
    } cm_station_t;

    // output port toward the frame consumer
    typedef struct packed {
        cm_chn_vec_t dval;   // one bit per channel
        cm_word_t    data;
    } cm_sdu_t;

endpackage

`default_nettype wire

/* cm_write_ctrl.sv */
/*
 * write controller
 * opens a write window on the select edge, steers the address
 * from the channel base and flags each finished frame
 */
`default_nettype none

module cm_write_ctrl (
    input  logic                     clk_12_5m,
    input  logic                     rst_12_5m,
    input  cm_mem_pkg::cm_wr_port_t  wr_port,
    output cm_mem_pkg::cm_ram_wr_t   ram_wr,
    output cm_mem_pkg::cm_chn_vec_t  frame_done
);

    import cm_mem_pkg::*;

    logic        sel_q;       // select history for edge
    logic        sof;         // frame start
    logic        eof;         // end-marked word being written
    logic        win_q;       // write window
    logic        wr_en_q;     // registered strobe
    cm_word_t    data_q;      // registered word
    cm_addr_t    addr_q;
    cm_chn_vec_t chn_win;     // window split per channel
    cm_chn_vec_t chn_win_q;

    assign sof = wr_port.sel && !sel_q;
    assign eof = wr_en_q && data_q[cm_eop_bit];

    // ------------------------------------------------------------------
    // window and strobe registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            sel_q   <= 1'b0;
            win_q   <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            sel_q   <= wr_port.sel;
            wr_en_q <= win_q && wr_port.wr_en;  // strobes outside the window dropped
            if (eof) begin
                win_q <= 1'b0;                  // end mark wins over a new edge
            end else if (sof) begin
                win_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_12_5m) begin
        data_q <= wr_port.data;
    end

    // address, base on start then one step per written word
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            addr_q <= '0;
        end else if (sof) begin
            addr_q <= cm_base_addr(wr_port.chn);
        end else if (wr_en_q) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign ram_wr = '{en: wr_en_q, addr: addr_q, data: data_q};

    // ------------------------------------------------------------------
    // frame done, falling edge of each channel window
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < cm_chn_num; i++) begin
            chn_win[i] = win_q && (wr_port.chn == cm_chn_t'(i));
        end
    end

    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            chn_win_q <= '0;
        end else begin
            chn_win_q <= chn_win;
        end
    end

    assign frame_done = chn_win_q & ~chn_win;  // one cycle per closed window

endmodule

`default_nettype wire

/* cm_cell_ram.sv */
/*
 * cell memory
 * 1K x 18 words, one write port, one read port
 * with a single registered read stage
 */
`default_nettype none

module cm_cell_ram (
    input  logic                    clk_12_5m,
    input  cm_mem_pkg::cm_ram_wr_t  ram_wr,
    input  cm_mem_pkg::cm_addr_t    rd_addr,
    output cm_mem_pkg::cm_word_t    rd_data
);

    import cm_mem_pkg::*;

    cm_word_t mem [1 << cm_addr_w];
    cm_word_t rd_data_q;

    always_ff @(posedge clk_12_5m) begin
        if (ram_wr.en) begin
            mem[ram_wr.addr] <= ram_wr.data;
        end
        rd_data_q <= mem[rd_addr];  // old data on a same-address write
    end

    assign rd_data = rd_data_q;

endmodule

`default_nettype wire

/* cm_empty_flags.sv */
/*
 * empty flags
 * one flag per channel, cleared by a finished frame or a
 * hot-plug edge on a written channel, set when read out
 */
`default_nettype none

module cm_empty_flags (
    input  logic                     clk_12_5m,
    input  logic                     rst_12_5m,
    input  cm_mem_pkg::cm_chn_vec_t  frame_done,
    input  cm_mem_pkg::cm_chn_vec_t  hot_plug_req,
    input  cm_mem_pkg::cm_chn_vec_t  rd_en,
    input  logic                     frame_end,
    output cm_mem_pkg::cm_chn_vec_t  cm_empty
);

    import cm_mem_pkg::*;

    cm_chn_vec_t hp_sync1;    // async pin, first stage
    cm_chn_vec_t hp_sync2;
    cm_chn_vec_t hp_prev;     // history for edge detect
    cm_chn_vec_t hp_edge;     // qualified rising edge
    cm_chn_vec_t written;     // frame seen since reset
    cm_chn_vec_t empty_set;
    cm_chn_vec_t empty_clr;
    cm_chn_vec_t empty_q;

    // ------------------------------------------------------------------
    // hot-plug synchronizer and edge
    // ------------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            hp_sync1 <= '0;
            hp_sync2 <= '0;
            hp_prev  <= '0;
            hp_edge  <= '0;
        end else begin
            hp_sync1 <= hot_plug_req;
            hp_sync2 <= hp_sync1;
            hp_prev  <= hp_sync2;
            hp_edge  <= hp_sync2 & ~hp_prev & written;  // never-written channels ignored
        end
    end

    // written record and the flags
    assign empty_set = rd_en & {cm_chn_num{frame_end}};  // last word read on that channel
    assign empty_clr = frame_done | hp_edge;

    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            written <= '0;
            empty_q <= '1;
        end else begin
            written <= written | frame_done;
            empty_q <= empty_set | (empty_q & ~empty_clr);  // set has priority
        end
    end

    assign cm_empty = empty_q;

endmodule

`default_nettype wire

/* cm_read_framer.sv */
/*
 * read framer
 * sequences the seven header words, steers the read address
 * into the channel region and passes the stored body through
 */
`default_nettype none

module cm_read_framer (
    input  logic                       clk_12_5m,
    input  logic                       rst_12_5m,
    input  cm_mem_pkg::cm_chn_vec_t    rd_en,
    input  cm_frame_pkg::cm_station_t  station,
    input  cm_mem_pkg::cm_word_t       rd_data,
    output cm_mem_pkg::cm_addr_t       rd_addr,
    output logic                       frame_end,
    output cm_frame_pkg::cm_sdu_t      sdu
);

    import cm_mem_pkg::*;
    import cm_frame_pkg::*;

    cm_head_e    pos_q;     // read sequence position
    cm_addr_t    ptr_q;     // address of the word in rd_data
    cm_chn_t     rd_chn;    // channel from one-hot enable
    cm_slot_t    slot;
    logic        adv;       // any reader active
    logic        body;
    cm_word_t    word_d;
    cm_chn_vec_t dval_q;
    cm_word_t    data_q;

    assign adv       = |rd_en;
    assign body      = (pos_q == head_body);
    assign frame_end = adv && body && rd_data[cm_eop_bit];

    always_comb begin
        case (rd_en)
            4'b0010: rd_chn = 2'd1;
            4'b0100: rd_chn = 2'd2;
            4'b1000: rd_chn = 2'd3;
            default: rd_chn = 2'd0;  // also idle
        endcase
    end

    assign slot = cm_slot_table[rd_chn];

    // ------------------------------------------------------------------
    // position and read pointer, both hold while rd_en is low
    // ------------------------------------------------------------------
    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            pos_q <= head_da;
            ptr_q <= '0;
        end else if (adv) begin
            if (!body) begin
                pos_q <= cm_head_e'(pos_q + 3'd1);
            end else if (rd_data[cm_eop_bit]) begin
                pos_q <= head_da;                   // frame done
            end
            if (pos_q == head_tick) begin
                ptr_q <= cm_base_addr(rd_chn);      // base word ready at head_body
            end else if (body) begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    // next word only when the current one is taken
    assign rd_addr = (adv && body) ? cm_addr_t'(ptr_q + 1'b1) : ptr_q;

    // ------------------------------------------------------------------
    // output word assembly
    // ------------------------------------------------------------------
    always_comb begin
        case (pos_q)
            head_da:    word_d = {cm_sof_tag, 6'd0, station.dst_sta_num, cm_box_num[2:1]};
            head_da_sa: word_d = {2'b00, cm_box_num[0], 1'b0, slot, 7'd0, station.master, 2'd0};
            head_sa:    word_d = '0;
            head_rsvd:  word_d = '0;
            head_type:  word_d = {2'b00, cm_cfg_type};
            head_tick:  word_d = {2'b00, cm_tick_pos};
            head_len:   word_d = {2'b00, cm_len_word};
            head_body:  word_d = {1'b0, rd_data[cm_eop_bit:0]};  // bit 17 cleared
            default:    word_d = '0;
        endcase
    end

    always_ff @(posedge clk_12_5m or negedge rst_12_5m) begin
        if (!rst_12_5m) begin
            dval_q <= '0;
        end else begin
            dval_q <= rd_en;  // valid one cycle after request
        end
    end

    always_ff @(posedge clk_12_5m) begin
        if (adv) begin
            data_q <= word_d;
        end
    end

    assign sdu = '{dval: dval_q, data: data_q};

endmodule

`default_nettype wire

/* cm_cell.sv */
/*
 * configuration memory cell, top level
 * host writes frames into four regions, readers get them
 * back behind a generated header
 */
`default_nettype none

module cm_cell (
    input  logic                       clk_12_5m,
    input  logic                       rst_12_5m,
    input  cm_mem_pkg::cm_wr_port_t    wr_port,
    input  cm_frame_pkg::cm_station_t  station,
    input  cm_mem_pkg::cm_chn_vec_t    hot_plug_req,
    input  cm_mem_pkg::cm_chn_vec_t    rd_en,
    output cm_mem_pkg::cm_chn_vec_t    cm_empty,
    output cm_frame_pkg::cm_sdu_t      sdu
);

    import cm_mem_pkg::*;

    cm_ram_wr_t  ram_wr;
    cm_addr_t    rd_addr;
    cm_word_t    rd_data;
    cm_chn_vec_t frame_done;  // write side to flags
    logic        frame_end;   // read side to flags

    cm_write_ctrl write_ctrl_i (
        .clk_12_5m  (clk_12_5m),
        .rst_12_5m  (rst_12_5m),
        .wr_port    (wr_port),
        .ram_wr     (ram_wr),
        .frame_done (frame_done)
    );

    cm_cell_ram cell_ram_i (
        .clk_12_5m (clk_12_5m),
        .ram_wr    (ram_wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    cm_empty_flags empty_flags_i (
        .clk_12_5m    (clk_12_5m),
        .rst_12_5m    (rst_12_5m),
        .frame_done   (frame_done),
        .hot_plug_req (hot_plug_req),
        .rd_en        (rd_en),
        .frame_end    (frame_end),
        .cm_empty     (cm_empty)
    );

    cm_read_framer read_framer_i (
        .clk_12_5m (clk_12_5m),
        .rst_12_5m (rst_12_5m),
        .rd_en     (rd_en),
        .station   (station),
        .rd_data   (rd_data),
        .rd_addr   (rd_addr),
        .frame_end (frame_end),
        .sdu       (sdu)
    );

endmodule

`default_nettype wire

/* cm_cell_assert.sv */
/*
 * read interface assertions for the cell, bound to the top
 */
`default_nettype none

module cm_cell_assert (
    input logic                       clk_12_5m,
    input logic                       rst_12_5m,
    input cm_mem_pkg::cm_chn_vec_t    rd_en,
    input cm_mem_pkg::cm_chn_vec_t    cm_empty,
    input cm_frame_pkg::cm_sdu_t      sdu,
    input logic                       frame_end
);

    timeunit 1ns;
    timeprecision 100ps;

    import cm_mem_pkg::*;

    // one reader at a time
    rd_en_onehot: assert property (@(posedge clk_12_5m) disable iff (!rst_12_5m)
        $onehot0(rd_en))
        else $error("read enable has more than one bit set");

    // valid is the request delayed by one
    dval_follows: assert property (@(posedge clk_12_5m) disable iff (!rst_12_5m)
        sdu.dval == $past(rd_en))
        else $error("valid vector differs from last cycle read enable");

    // flag already low and steady when the last word of a read is taken
    for (genvar i = 0; i < cm_chn_num; i++) begin : g_chn
        empty_on_end: assert property (@(posedge clk_12_5m) disable iff (!rst_12_5m)
            (frame_end && rd_en[i]) |-> (!cm_empty[i] && !$fell(cm_empty[i])))
            else $error("empty flag of channel %0d not held low through frame end", i);
    end

endmodule

`default_nettype wire

/* tb_cm_cell.sv */
/*
 * testbench for the configuration memory cell
 * replays write, hot-plug and read records from the golden file
 * and checks empty flags and framed output words
 */
`default_nettype none

module tb_cm_cell;

    timeunit 1ns;
    timeprecision 100ps;

    import cm_mem_pkg::*;
    import cm_frame_pkg::*;

    localparam int gold_depth = 256;

    logic        clk_12_5m;
    logic        rst_12_5m;
    cm_wr_port_t wr_port;
    cm_station_t station;
    cm_chn_vec_t hot_plug_req;
    cm_chn_vec_t rd_en;
    cm_chn_vec_t cm_empty;
    cm_sdu_t     sdu;

    logic [31:0] gold [0:gold_depth-1];   // op, channel, value
    cm_word_t    frame_q[$];              // words of the frame being written
    cm_word_t    exp_q[$];                // expected words of one read
    cm_chn_vec_t exp_empty;               // flag model
    cm_chn_vec_t written_m;               // channels written since reset
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          err_mark;                // errors before the current test

    cm_cell dut_i (
        .clk_12_5m    (clk_12_5m),
        .rst_12_5m    (rst_12_5m),
        .wr_port      (wr_port),
        .station      (station),
        .hot_plug_req (hot_plug_req),
        .rd_en        (rd_en),
        .cm_empty     (cm_empty),
        .sdu          (sdu)
    );

    bind cm_cell cm_cell_assert assert_i (
        .clk_12_5m (clk_12_5m),
        .rst_12_5m (rst_12_5m),
        .rd_en     (rd_en),
        .cm_empty  (cm_empty),
        .sdu       (sdu),
        .frame_end (frame_end)
    );

    initial begin
        clk_12_5m = 1'b0;
        forever #100 clk_12_5m = ~clk_12_5m;   // 200 ns period
    end

    // ------------------------------------------------------------------
    // helpers, all return 10 ns after a rising edge
    // ------------------------------------------------------------------
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_12_5m);
        #10;
    endtask

    // no read pending, so no valid bit either
    task automatic idle_cycle();
        next_cycle();
        check_val("sdu.dval", sdu.dval, '0);
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            idle_cycle();
            check_val("cm_empty", cm_empty, exp_empty);
        end
    endtask

    task automatic write_frame(input cm_chn_t ch);
        int k;
        wr_port.sel   = 1'b1;
        wr_port.chn   = ch;
        wr_port.wr_en = 1'b0;
        idle_cycle();                        // select edge, window opens
        for (k = 0; k < frame_q.size(); k++) begin
            wr_port.wr_en = 1'b1;
            wr_port.data  = frame_q[k];
            idle_cycle();
        end
        wr_port.wr_en = 1'b0;
        wr_port.sel   = 1'b0;
        wr_port.data  = '0;
        idle_cycle();
        check_val("cm_empty", cm_empty, exp_empty);  // end mark written, flag not yet
        exp_empty[ch] = 1'b0;
        written_m[ch] = 1'b1;
        idle_cycle();
        check_val("cm_empty", cm_empty, exp_empty);  // 2 cycles after last strobe
    endtask

    task automatic hot_plug(input cm_chn_t ch);
        int n;
        int lat;
        lat = 0;
        hot_plug_req[ch] = 1'b1;
        for (n = 1; n <= 8; n++) begin
            idle_cycle();
            if (n == 2) begin
                hot_plug_req[ch] = 1'b0;
            end
            if (lat == 0 && !cm_empty[ch]) begin
                lat = n;                     // first cycle seen low
            end
        end
        if (written_m[ch]) begin
            if (lat == 0 || lat > 4) begin
                $display("ERROR: hot-plug on channel %0d did not clear its empty flag in 4 cycles",
                         ch);
                n_errors++;
            end
            exp_empty[ch] = 1'b0;
        end
        check_val("cm_empty", cm_empty, exp_empty);
    endtask

    task automatic read_frame(input cm_chn_t ch, input logic empty_after);
        int          t;
        int          i;
        cm_chn_vec_t oh;
        oh     = '0;
        oh[ch] = 1'b1;
        t      = 0;
        while (cm_empty[ch] && t < 16) begin  // reader waits for data
            idle_cycle();
            t++;
        end
        if (cm_empty[ch]) begin
            $display("ERROR: channel %0d stayed empty, read not started", ch);
            n_errors++;
        end else begin
            rd_en = oh;
            for (i = 0; i < exp_q.size(); i++) begin
                next_cycle();                // word i out one cycle after request
                check_val("sdu.dval", sdu.dval, oh);
                check_val("sdu.data", sdu.data, exp_q[i]);
                if (i == exp_q.size() - 1) begin
                    rd_en = '0;              // end-marked word was the last request
                end
            end
            exp_empty[ch] = empty_after;
            check_val("cm_empty", cm_empty, exp_empty);
        end
    endtask

    // ------------------------------------------------------------------
    // record replay
    // ------------------------------------------------------------------
    initial begin
        int          idx;
        logic [3:0]  op;
        cm_chn_t     ch;
        logic        empty_after;
        rst_12_5m    = 1'b0;
        wr_port      = '0;
        station      = '{dst_sta_num: 8'h5A, master: 1'b1};
        hot_plug_req = '0;
        rd_en        = '0;
        exp_empty    = '1;
        written_m    = '0;
        n_checks     = 0;
        n_errors     = 0;
        n_tests      = 0;
        err_mark     = 0;
        $readmemh("cm_cell_golden.txt", gold);
        repeat (8) @(posedge clk_12_5m);
        #10;
        rst_12_5m = 1'b1;
        idx = 0;
        while (idx < gold_depth && gold[idx][31:28] !== 4'hE) begin
            op = gold[idx][31:28];
            ch = gold[idx][25:24];
            idx++;
            case (op)
                4'h1: begin
                    frame_q.push_back(gold[idx-1][17:0]);
                    if (gold[idx-1][cm_eop_bit]) begin  // end mark, frame complete
                        write_frame(ch);
                        frame_q.delete();
                    end
                end
                4'h2: hot_plug(ch);
                4'h3: begin
                    empty_after = gold[idx-1][0];
                    exp_q.delete();
                    while (idx < gold_depth && gold[idx][31:28] === 4'h4) begin
                        exp_q.push_back(gold[idx][17:0]);
                        idx++;
                    end
                    read_frame(ch, empty_after);
                end
                4'h6: idle_check(int'(gold[idx-1][7:0]));
                4'hF: begin
                    n_tests++;
                    $display("test %0d done, %0d errors", gold[idx-1][7:0], n_errors - err_mark);
                    err_mark = n_errors;
                end
                default: begin
                    $display("ERROR: unknown golden record 0x%0h at line index %0d",
                             gold[idx-1], idx - 1);
                    n_errors++;
                end
            endcase
        end
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // run limit
    initial begin
        repeat (5000) @(posedge clk_12_5m);
        $display("ERROR: simulation limit reached before the last golden record");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* cm_cell_golden.txt */
// record op[31:28] chn[27:24] value[23:0] in hex; station 0x5a, master 1
// op 1 write word, 2 hot-plug, 3 read (value is empty after), 4 expected word
// op 6 idle cycles, F end of test, E end of records
60000008
F0000001
// two-word frame on channel 1, bit 17 set on the first
1102A5A5
1101C3C3
F0000002
// read channel 1, slot 4
31000001
40020168
40001004
40000000
40000000
40000C01
40000000
40000100
4000A5A5
4001C3C3
F0000003
// hot-plug re-arms channel 1, channel 2 never written
21000000
31000001
40020168
40001004
40000000
40000000
40000C01
40000000
40000100
4000A5A5
4001C3C3
22000000
F0000004
// three words on channel 0, one on channel 3
10000111
10000222
10010333
1303FFFF
33000001
40020168
40001804
40000000
40000000
40000C01
40000000
40000100
4001FFFF
30000001
40020168
40000C04
40000000
40000000
40000C01
40000000
40000100
40000111
40000222
40010333
F0000005
E0000000

/* vlog.f */
cm_mem_pkg.sv
cm_frame_pkg.sv
cm_write_ctrl.sv
cm_cell_ram.sv
cm_empty_flags.sv
cm_read_framer.sv
cm_cell.sv
cm_cell_assert.sv
tb_cm_cell.sv

/* Bender.yml */
package:
  name: cm_cell

sources:
  - files:
      - cm_mem_pkg.sv
      - cm_frame_pkg.sv
      - cm_write_ctrl.sv
      - cm_cell_ram.sv
      - cm_empty_flags.sv
      - cm_read_framer.sv
      - cm_cell.sv
  - target: simulation
    files:
      - cm_cell_assert.sv
      - tb_cm_cell.sv
